// File: src/controlPkg.sv
package controlPkg;

	localparam int OpcodeWidth = 6; // Also the funct field
	localparam int ImmFieldWidth = 26;

	typedef enum logic [OpcodeWidth-1:0] {
		opSpecial = 6'h00,
		opJump = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	typedef enum logic [OpcodeWidth-1:0] {
		fnSllNop = 6'h00,
		fnJr = 6'h08,
		fnBreak = 6'h0d,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24
	} functT;

	typedef enum logic [3:0] {
		clsNop, clsArith, clsArithImm, clsBranchEq, clsBranchNe, clsLoad,
		clsStore, clsJump, clsJumpLink, clsJumpReg, clsHalt, clsIllegal
	} instrClassT;

	// ALU command codes as the datapath ALU expects them
	typedef enum logic [2:0] {
		aluLoad = 3'b000,
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluNone = 3'b111
	} aluOpT;

	typedef enum logic [4:0] {
		stepPowerUp, stepIdle, stepFetchAddr, stepFetchWait, stepDecode,
		stepArithExec, stepArithCheck, stepArithWrite, stepBranchAddr, stepBranchCompare,
		stepMemAddr, stepMemIssue, stepLoadWait, stepLoadCapture, stepLoadWrite,
		stepStoreWrite, stepJumpLink, stepJumpReg, stepJump, stepExcSave,
		stepExcVector, stepExcLoad, stepHalt
	} stepT;

	typedef enum logic {causeIllegalOpcode, causeArithOverflow} excCauseT;

	typedef enum logic [1:0] {srcAPc = 2'd0, srcARegA = 2'd1} aluSrcAT;
	typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBImmShift} aluSrcBT;

	// Next PC value
	typedef enum logic [2:0] {
		resultAluResult = 3'd0,
		resultAluOut = 3'd1,
		resultJumpTarget = 3'd2,
		resultRegA = 3'd3,
		resultVectorData = 3'd5 // Handler address read from the vector
	} resultSelT;

	// Memory address source
	typedef enum logic [2:0] {
		pcSrcPc = 3'd0,
		pcSrcAluOut = 3'd1,
		pcSrcExcOpcodeVector = 3'd2,
		pcSrcExcOverflowVector = 3'd3
	} pcSrcT;

	typedef enum logic [1:0] {regDstRt, regDstRd, regDstRa, regDstSp} regDstT;
	typedef enum logic [1:0] {writeAluOut, writeMemData, writePcLink, writeStackInit} writeDataSelT;

endpackage

// File: src/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf import controlPkg::*;;
	instrClassT instrClass;
	aluOpT aluOp;
	logic trapOverflow; // Overflow raises an exception
	regDstT regDst;

	modport decoder (
		output instrClass, aluOp, trapOverflow, regDst
	);

	modport sequencer (
		input instrClass, aluOp, trapOverflow, regDst
	);
endinterface

// File: src/stepIf.sv
`timescale 1ns/1ps

interface stepIf import controlPkg::*;;
	stepT step;
	aluOpT aluOp; // Held from decode
	regDstT regDst;
	excCauseT cause;
	logic branchNe;

	modport sequencer (
		output step, aluOp, regDst, cause, branchNe
	);

	modport encoder (
		input step, aluOp, regDst, cause, branchNe
	);
endinterface

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import controlPkg::*; (
	input logic [OpcodeWidth-1:0] opcode,
	input logic [OpcodeWidth-1:0] funct,
	input logic [ImmFieldWidth-1:0] instrLow,
	decodeIf.decoder decode
);

	always_comb begin
		decode.instrClass = clsIllegal;
		decode.aluOp = aluNone;
		decode.trapOverflow = 1'b0;
		decode.regDst = regDstRt;
		case (opcode)
			opSpecial: begin
				decode.regDst = regDstRd;
				case (funct)
					fnSllNop: decode.instrClass = (instrLow == '0) ? clsNop : clsIllegal; // Real shifts trap
					fnJr: decode.instrClass = clsJumpReg;
					fnBreak: decode.instrClass = clsHalt;
					fnAdd: begin
						decode.instrClass = clsArith;
						decode.aluOp = aluAdd;
						decode.trapOverflow = 1'b1;
					end
					fnSub: begin
						decode.instrClass = clsArith;
						decode.aluOp = aluSub;
						decode.trapOverflow = 1'b1;
					end
					fnAnd: begin
						decode.instrClass = clsArith;
						decode.aluOp = aluAnd;
					end
					default: decode.instrClass = clsIllegal;
				endcase
			end
			opJump: decode.instrClass = clsJump;
			opJal: decode.instrClass = clsJumpLink;
			opBeq: decode.instrClass = clsBranchEq;
			opBne: decode.instrClass = clsBranchNe;
			opAddi: begin
				decode.instrClass = clsArithImm;
				decode.aluOp = aluAdd;
				decode.trapOverflow = 1'b1;
			end
			opAddiu: begin
				decode.instrClass = clsArithImm;
				decode.aluOp = aluAdd; // Overflow ignored
			end
			opLw: begin
				decode.instrClass = clsLoad;
				decode.aluOp = aluAdd;
			end
			opSw: begin
				decode.instrClass = clsStore;
				decode.aluOp = aluAdd;
			end
			default: decode.instrClass = clsIllegal;
		endcase
	end

	classInRange: assert final (!$isunknown(decode.instrClass)
		&& decode.instrClass inside {[clsNop:clsIllegal]})
		else $error("instrClass out of range for opcode %h", opcode);

endmodule

// File: src/mainSequencer.sv
`timescale 1ns/1ps

module mainSequencer import controlPkg::*; (
	input logic Clk,
	input logic Reset,
	input logic overflow,
	decodeIf.sequencer decode,
	stepIf.sequencer step,
	output stepT state
);

	stepT curStep;
	stepT nextStep;
	aluOpT aluOpQ;
	regDstT regDstQ;
	logic branchNeQ;
	excCauseT causeQ;

	always_ff @(posedge Clk, posedge Reset) begin
		if (Reset) begin
			curStep <= stepPowerUp;
		end else begin
			curStep <= nextStep;
		end
	end

	always_comb begin
		nextStep = stepIdle; // Last step of every instruction
		case (curStep)
			stepPowerUp: nextStep = stepIdle;
			stepIdle: nextStep = stepFetchAddr;
			stepFetchAddr: nextStep = stepFetchWait;
			stepFetchWait: nextStep = stepDecode;
			stepDecode: begin
				case (decode.instrClass)
					clsNop: nextStep = stepIdle;
					clsArith, clsArithImm: nextStep = stepArithExec;
					clsBranchEq, clsBranchNe: nextStep = stepBranchAddr;
					clsLoad, clsStore: nextStep = stepMemAddr;
					clsJump: nextStep = stepJump;
					clsJumpLink: nextStep = stepJumpLink;
					clsJumpReg: nextStep = stepJumpReg;
					clsHalt: nextStep = stepHalt;
					default: nextStep = stepExcSave;
				endcase
			end
			stepArithExec: nextStep = stepArithCheck;
			stepArithCheck: begin
				// ADDIU and AND never trap
				nextStep = (overflow && decode.trapOverflow) ? stepExcSave : stepArithWrite;
			end
			stepBranchAddr: nextStep = stepBranchCompare;
			stepMemAddr: nextStep = stepMemIssue;
			stepMemIssue: begin
				nextStep = (decode.instrClass == clsLoad) ? stepLoadWait : stepStoreWrite;
			end
			stepLoadWait: nextStep = stepLoadCapture;
			stepLoadCapture: nextStep = stepLoadWrite;
			stepJumpLink: nextStep = stepJump;
			stepExcSave: nextStep = stepExcVector;
			stepExcVector: nextStep = stepExcLoad;
			stepHalt: nextStep = stepHalt; // Only Reset leaves
			default: nextStep = stepIdle;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (curStep == stepDecode) begin
			aluOpQ <= decode.aluOp;
			regDstQ <= decode.regDst;
			branchNeQ <= (decode.instrClass == clsBranchNe);
		end
		if (nextStep == stepExcSave) begin
			causeQ <= (curStep == stepArithCheck) ? causeArithOverflow : causeIllegalOpcode;
		end
	end

	assign step.step = curStep;
	assign step.aluOp = aluOpQ;
	assign step.regDst = regDstQ;
	assign step.cause = causeQ;
	assign step.branchNe = branchNeQ;
	assign state = curStep;

	excEntry: assert property (@(posedge Clk) disable iff (Reset)
		(curStep == stepExcSave) |-> $past(curStep) inside {stepDecode, stepArithCheck})
		else $error("excSave entered from %s", $past(curStep));

	haltSticky: assert property (@(posedge Clk) disable iff (Reset)
		(curStep == stepHalt) |=> (curStep == stepHalt))
		else $error("halt left without Reset");

endmodule

// File: src/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder import controlPkg::*; (
	stepIf.encoder step,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluControl,
	output resultSelT resultSel,
	output pcSrcT pcSrc,
	output logic branchNe,
	output regDstT regDstSel,
	output writeDataSelT writeDataSel,
	output logic memWrite,
	output logic regWrite,
	output logic irWrite,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic loadA,
	output logic loadB,
	output logic loadAluOut,
	output logic loadMemData,
	output logic loadEpc
);

	pcSrcT excVector;

	assign excVector = (step.cause == causeArithOverflow) ? pcSrcExcOverflowVector
		: pcSrcExcOpcodeVector;

	always_comb begin
		aluSrcA = srcAPc;
		aluSrcB = srcBRegB;
		aluControl = aluLoad;
		resultSel = resultAluResult;
		pcSrc = pcSrcPc;
		branchNe = 1'b0;
		regDstSel = regDstRt;
		writeDataSel = writeAluOut;
		memWrite = 1'b0;
		regWrite = 1'b0;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		loadA = 1'b0;
		loadB = 1'b0;
		loadAluOut = 1'b0;
		loadMemData = 1'b0;
		loadEpc = 1'b0;
		case (step.step)
			stepPowerUp: begin
				regWrite = 1'b1; // Stack pointer init
				regDstSel = regDstSp;
				writeDataSel = writeStackInit;
			end
			stepFetchAddr: begin
				aluSrcB = srcBFour;
				aluControl = aluAdd;
			end
			stepFetchWait: irWrite = 1'b1;
			stepDecode: begin
				aluSrcB = srcBFour; // PC + 4
				aluControl = aluAdd;
				irWrite = 1'b1;
				pcWrite = 1'b1;
				loadA = 1'b1;
				loadB = 1'b1;
			end
			stepArithExec, stepArithCheck: begin
				aluSrcA = srcARegA;
				aluSrcB = (step.regDst == regDstRd) ? srcBRegB : srcBImm;
				aluControl = step.aluOp;
				loadAluOut = 1'b1;
			end
			stepArithWrite, stepLoadWrite: begin
				regWrite = 1'b1;
				regDstSel = step.regDst;
				writeDataSel = (step.step == stepLoadWrite) ? writeMemData : writeAluOut;
			end
			stepBranchAddr: begin
				aluSrcB = srcBImmShift; // Target into ALUOut
				aluControl = aluAdd;
				loadAluOut = 1'b1;
				branchNe = step.branchNe;
			end
			stepBranchCompare: begin
				aluSrcA = srcARegA;
				aluControl = aluSub;
				resultSel = resultAluOut;
				pcWriteCond = 1'b1;
				branchNe = step.branchNe;
			end
			stepMemAddr: begin
				aluSrcA = srcARegA;
				aluSrcB = srcBImm;
				aluControl = step.aluOp;
				loadAluOut = 1'b1;
			end
			stepMemIssue, stepLoadWait: pcSrc = pcSrcAluOut;
			stepLoadCapture: begin
				pcSrc = pcSrcAluOut;
				loadMemData = 1'b1;
			end
			stepStoreWrite: begin
				pcSrc = pcSrcAluOut;
				memWrite = 1'b1;
			end
			stepJumpLink: begin
				regWrite = 1'b1;
				regDstSel = regDstRa;
				writeDataSel = writePcLink;
			end
			stepJump: begin
				resultSel = resultJumpTarget;
				pcWrite = 1'b1;
			end
			stepJumpReg: begin
				resultSel = resultRegA;
				pcWrite = 1'b1;
			end
			stepExcSave: begin
				aluSrcB = srcBFour; // EPC gets PC - 4
				aluControl = aluSub;
				pcSrc = excVector;
				loadEpc = 1'b1;
			end
			stepExcVector, stepExcLoad: begin
				resultSel = resultVectorData;
				pcSrc = excVector;
				pcWrite = 1'b1;
			end
			default: ; // idle and halt drive nothing
		endcase
	end

	noWriteClash: assert final (!(memWrite && regWrite))
		else $error("memWrite and regWrite together in step %s", step.step.name());

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import controlPkg::*; (
	input logic Clk,
	input logic Reset,
	input logic [OpcodeWidth-1:0] opcode,
	input logic [OpcodeWidth-1:0] funct,
	input logic [ImmFieldWidth-1:0] instrLow,
	input logic overflow,
	output stepT state,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output aluOpT aluControl,
	output resultSelT resultSel,
	output pcSrcT pcSrc,
	output logic branchNe,
	output regDstT regDstSel,
	output writeDataSelT writeDataSel,
	output logic memWrite,
	output logic regWrite,
	output logic irWrite,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic loadA,
	output logic loadB,
	output logic loadAluOut,
	output logic loadMemData,
	output logic loadEpc
);

	decodeIf decodeBus();
	stepIf stepBus();

	instrDecoder i_instrDecoder (
		.opcode(opcode),
		.funct(funct),
		.instrLow(instrLow),
		.decode(decodeBus)
	);

	mainSequencer i_mainSequencer (
		.Clk(Clk),
		.Reset(Reset),
		.overflow(overflow),
		.decode(decodeBus),
		.step(stepBus),
		.state(state)
	);

	controlEncoder i_controlEncoder (
		.step(stepBus),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.resultSel(resultSel),
		.pcSrc(pcSrc),
		.branchNe(branchNe),
		.regDstSel(regDstSel),
		.writeDataSel(writeDataSel),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.irWrite(irWrite),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.loadA(loadA),
		.loadB(loadB),
		.loadAluOut(loadAluOut),
		.loadMemData(loadMemData),
		.loadEpc(loadEpc)
	);

endmodule

// File: verification/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb import controlPkg::*; ();

	localparam int NumInstr = 200;
	localparam int ClkPeriod = 40;
	localparam int WatchdogCycles = NumInstr * 9 + 80; // Reset and BREAK tests fit in the margin

	typedef enum int {
		kindNop, kindAdd, kindSub, kindAnd, kindAddi, kindAddiu, kindBeq, kindBne,
		kindLw, kindSw, kindJ, kindJr, kindJal, kindIllegal
	} kindT;

	logic Clk;
	logic Reset;
	logic [OpcodeWidth-1:0] opcode;
	logic [OpcodeWidth-1:0] funct;
	logic [ImmFieldWidth-1:0] instrLow;
	logic overflow;
	stepT state;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluControl;
	resultSelT resultSel;
	pcSrcT pcSrc;
	logic branchNe;
	regDstT regDstSel;
	writeDataSelT writeDataSel;
	logic memWrite;
	logic regWrite;
	logic irWrite;
	logic pcWrite;
	logic pcWriteCond;
	logic loadA;
	logic loadB;
	logic loadAluOut;
	logic loadMemData;
	logic loadEpc;

	logic [31:0] lfsr;
	int errors;
	int errorsAtStart;
	int testsRun;
	int testsFailed;

	// Model expectations for the instruction in flight
	int expCycles;
	int expRegWrite;
	int expLoadEpc;
	int expMemWrite;
	int expLoadMemData;
	int expPcWriteCond;
	int expPcWrite;
	aluOpT expAlu;
	aluSrcBT expSrcB;
	resultSelT expResult;
	regDstT expDst;
	writeDataSelT expWriteData;
	pcSrcT expVector;
	logic expBranchNe;

	controlUnit i_dut (.*);

	always #(ClkPeriod / 2) Clk = ~Clk;

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Timeout: the DUT stopped making progress");
		$display("tests failed");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [8:0] strobeBits();
		return {memWrite, irWrite, pcWrite, pcWriteCond, loadEpc,
			loadA, loadB, loadAluOut, loadMemData};
	endfunction

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		errors++;
	endtask

	task automatic reportProblem(input string what);
		$display("Error: %s", what);
		errors++;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors != errorsAtStart) begin
			testsFailed++;
		end
		$display("test %0d %s: %s", testsRun, name, (errors == errorsAtStart) ? "ok" : "fail");
		errorsAtStart = errors;
	endtask

	task automatic checkPowerUp();
		if (state !== stepPowerUp) reportValue("state", stepPowerUp, state);
		if (regWrite !== 1'b1) reportValue("regWrite", 1, regWrite);
		if (writeDataSel !== writeStackInit) reportValue("writeDataSel", writeStackInit, writeDataSel);
		if (regDstSel !== regDstSp) reportValue("regDstSel", regDstSp, regDstSel);
		if (strobeBits() !== '0) reportValue("strobes", 0, strobeBits());
	endtask

	task automatic applyReset();
		@(posedge Clk);
		Reset <= 1'b1;
		repeat (2) begin
			@(negedge Clk);
			checkPowerUp();
			@(posedge Clk);
		end
		Reset <= 1'b0;
		@(negedge Clk);
		checkPowerUp(); // Release edge still sees Reset
		@(negedge Clk);
		if (state !== stepIdle) reportValue("state", stepIdle, state);
	endtask

	task automatic setExpected(input kindT kind, input logic ov);
		logic trap;
		trap = ov && (kind inside {kindAdd, kindSub, kindAddi});
		expRegWrite = 0;
		expLoadEpc = 0;
		expMemWrite = 0;
		expLoadMemData = 0;
		expPcWriteCond = 0;
		expPcWrite = 1; // PC + 4 in decode
		expAlu = aluAdd;
		expSrcB = srcBRegB;
		expResult = resultAluResult;
		expDst = regDstRt;
		expWriteData = writeAluOut;
		expVector = trap ? pcSrcExcOverflowVector : pcSrcExcOpcodeVector;
		expBranchNe = (kind == kindBne);
		case (kind)
			kindNop: expCycles = 4;
			kindAdd, kindSub, kindAnd, kindAddi, kindAddiu: begin
				expCycles = trap ? 9 : 7;
				expRegWrite = trap ? 0 : 1;
				expLoadEpc = trap ? 1 : 0;
				expPcWrite = trap ? 3 : 1;
				if (trap) expResult = resultVectorData;
				if (kind == kindSub) expAlu = aluSub;
				else if (kind == kindAnd) expAlu = aluAnd;
				if (kind inside {kindAdd, kindSub, kindAnd}) expDst = regDstRd;
				else expSrcB = srcBImm; // Immediate operand
			end
			kindBeq, kindBne: begin
				expCycles = 6;
				expPcWriteCond = 1;
			end
			kindLw: begin
				expCycles = 9;
				expLoadMemData = 1;
				expRegWrite = 1;
				expWriteData = writeMemData;
			end
			kindSw: begin
				expCycles = 7;
				expMemWrite = 1;
			end
			kindJ, kindJr: begin
				expCycles = 5;
				expPcWrite = 2;
				expResult = (kind == kindJr) ? resultRegA : resultJumpTarget;
			end
			kindJal: begin
				expCycles = 6;
				expRegWrite = 1;
				expPcWrite = 2;
				expResult = resultJumpTarget;
				expDst = regDstRa;
				expWriteData = writePcLink;
			end
			default: begin
				expCycles = 7; // Illegal opcode
				expLoadEpc = 1;
				expPcWrite = 3;
				expResult = resultVectorData;
			end
		endcase
	endtask

	task automatic presentInstruction(input kindT kind, input logic ov);
		logic [5:0] opc;
		logic [5:0] fn;
		logic [31:0] upper;
		logic [31:0] variant;
		opc = opSpecial;
		fn = 6'(randBits(6));
		upper = randBits(20);
		variant = randBits(2);
		case (kind)
			kindNop: begin
				fn = fnSllNop;
				upper = '0;
			end
			kindAdd: fn = fnAdd;
			kindSub: fn = fnSub;
			kindAnd: fn = fnAnd;
			kindJr: fn = fnJr;
			kindAddi: opc = opAddi;
			kindAddiu: opc = opAddiu;
			kindBeq: opc = opBeq;
			kindBne: opc = opBne;
			kindLw: opc = opLw;
			kindSw: opc = opSw;
			kindJ: opc = opJump;
			kindJal: opc = opJal;
			default: begin
				if (variant == 0) begin
					fn = fnSllNop;
					upper[0] = 1'b1; // Real shift, not a NOP
				end else if (variant == 1) begin
					while (fn inside {fnSllNop, fnJr, fnBreak, fnAdd, fnSub, fnAnd})
						fn = 6'(randBits(6));
				end else begin
					opc = 6'(randBits(6));
					while (opc inside {opSpecial, opJump, opJal, opBeq, opBne, opAddi, opAddiu, opLw, opSw})
						opc = 6'(randBits(6));
				end
			end
		endcase
		@(posedge Clk);
		opcode <= opc;
		funct <= fn;
		instrLow <= {upper[19:0], fn};
		overflow <= ov; // Held for the whole instruction
	endtask

	task automatic measureInstruction();
		int cycles;
		int regWrites;
		int loadEpcs;
		int memWrites;
		int loadMemDatas;
		int pcWriteConds;
		int pcWrites;
		int irWrites;
		cycles = 1; // Idle cycle
		regWrites = 0;
		loadEpcs = 0;
		memWrites = 0;
		loadMemDatas = 0;
		pcWriteConds = 0;
		pcWrites = 0;
		irWrites = 0;
		do begin
			@(negedge Clk);
			if (state !== stepIdle) begin
				cycles++;
				if (regWrite) begin
					regWrites++;
					if (regDstSel !== expDst) reportValue("regDstSel", expDst, regDstSel);
					if (writeDataSel !== expWriteData) reportValue("writeDataSel", expWriteData, writeDataSel);
				end
				if (loadEpc) begin
					loadEpcs++;
					if (pcSrc !== expVector) reportValue("pcSrc", expVector, pcSrc);
				end
				if (pcWriteCond) begin
					pcWriteConds++;
					if (branchNe !== expBranchNe) reportValue("branchNe", expBranchNe, branchNe);
				end
				if (state === stepArithExec) begin
					if (aluControl !== expAlu) reportValue("aluControl", expAlu, aluControl);
					if (aluSrcA !== srcARegA) reportValue("aluSrcA", srcARegA, aluSrcA);
					if (aluSrcB !== expSrcB) reportValue("aluSrcB", expSrcB, aluSrcB);
				end
				if (pcWrite && state !== stepDecode && resultSel !== expResult)
					reportValue("resultSel", expResult, resultSel);
				memWrites += memWrite;
				loadMemDatas += loadMemData;
				pcWrites += pcWrite;
				irWrites += irWrite;
			end
		end while (state !== stepIdle && cycles < 16);
		if (state !== stepIdle) reportProblem("instruction never returned to idle");
		if (cycles != expCycles) reportValue("cycles", expCycles, cycles);
		if (regWrites != expRegWrite) reportValue("regWrite count", expRegWrite, regWrites);
		if (loadEpcs != expLoadEpc) reportValue("loadEpc count", expLoadEpc, loadEpcs);
		if (memWrites != expMemWrite) reportValue("memWrite count", expMemWrite, memWrites);
		if (loadMemDatas != expLoadMemData) reportValue("loadMemData count", expLoadMemData, loadMemDatas);
		if (pcWriteConds != expPcWriteCond) reportValue("pcWriteCond count", expPcWriteCond, pcWriteConds);
		if (pcWrites != expPcWrite) reportValue("pcWrite count", expPcWrite, pcWrites);
		if (irWrites != 2) reportValue("irWrite count", 2, irWrites);
	endtask

	task automatic breakTest();
		int waited;
		@(posedge Clk);
		opcode <= opSpecial;
		funct <= fnBreak;
		instrLow <= {20'h0, fnBreak};
		waited = 0;
		do begin
			@(negedge Clk);
			waited++;
		end while (state !== stepHalt && waited < 8);
		if (state !== stepHalt) reportProblem("BREAK did not reach the halt state");
		repeat (20) begin
			@(negedge Clk);
			if (state !== stepHalt) reportValue("state", stepHalt, state);
			if ({regWrite, strobeBits()} !== '0) reportValue("strobes", 0, {regWrite, strobeBits()});
		end
		applyReset();
	endtask

	initial begin
		kindT kind;
		logic ov;
		Clk = 1'b0;
		Reset = 1'b1;
		opcode = '0;
		funct = '0;
		instrLow = '0;
		overflow = 1'b0;
		lfsr = 32'h37e487e8;
		errors = 0;
		errorsAtStart = 0;
		testsRun = 0;
		testsFailed = 0;
		applyReset();
		finishTest("reset");
		for (int n = 0; n < NumInstr; n++) begin
			if (randBits(3) == 0) kind = kindIllegal; // About one in eight
			else kind = kindT'(randBits(4) % 13);
			ov = (randBits(1) != 0);
			setExpected(kind, ov);
			presentInstruction(kind, ov);
			measureInstruction();
			finishTest(kind.name());
		end
		breakTest();
		finishTest("break");
		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			testsRun, testsRun - testsFailed, testsFailed, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: sources.f
src/controlPkg.sv
src/decodeIf.sv
src/stepIf.sv
src/instrDecoder.sv
src/mainSequencer.sv
src/controlEncoder.sv
src/controlUnit.sv
verification/controlUnitTb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - src/controlPkg.sv
  - src/decodeIf.sv
  - src/stepIf.sv
  - src/instrDecoder.sv
  - src/mainSequencer.sv
  - src/controlEncoder.sv
  - src/controlUnit.sv
  - target: test
    files:
      - verification/controlUnitTb.sv
